// File: sim.f
+incdir+rtl
rtl/gb_bus_pkg.sv
rtl/gb_ram.sv
rtl/gb_addr_decode.sv
rtl/gb_oam_dma.sv
rtl/gb_bus_arbiter.sv
rtl/gb_bus_top.sv
verif/gb_bus_properties.sv
verif/gb_bus_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module gb_bus_tb \
	-f sim.f \
	-o gb_bus_sim

./obj_dir/gb_bus_sim

// File: verif/gb_bus_tb.sv
`timescale 1ns/1ps
`include "gb_bus_config.svh"

module gb_bus_tb;

	import gb_bus_pkg::*;

	// About 800 preload cycles, one cycle per op, 12 DMAs of about 325 cycles each
	localparam int NUM_OPS     = 3000;
	localparam int DMA_EVERY   = 250;
	localparam int CYCLE_LIMIT = 20000;

	logic  gbclk, rst, cpu_rd, cpu_wr, ppu_vram_req, ppu_oam_req;
	logic  ext_rd, ext_wr, dma_active;
	addr_t cpu_adr, ppu_adr, ext_adr;
	data_t cpu_wdata, ext_rdata, cpu_rdata, ppu_vram_data, ppu_oam_data, ext_wdata;

	data_t vram_m [`GB_VRAM_DEPTH];
	data_t oam_m [`GB_OAM_DEPTH];
	data_t hram_m [`GB_HRAM_DEPTH];
	data_t page_m, last_rd, d, p;
	addr_t a;
	int    cycles = 0;
	int    kind, idx, r;

	gb_bus_top UUT (
		.gbclk, .rst, .cpu_adr, .cpu_wdata, .cpu_rd, .cpu_wr,
		.ppu_vram_req, .ppu_oam_req, .ppu_adr, .ext_rdata,
		.cpu_rdata, .ppu_vram_data, .ppu_oam_data,
		.ext_adr, .ext_rd, .ext_wr, .ext_wdata, .dma_active
	);

	// External device answers low address byte XOR high byte
	assign ext_rdata = ext_adr[7:0] ^ ext_adr[15:8];

	initial begin
		gbclk = 1'b0;
		forever #20 gbclk = ~gbclk;
	end

	always @(posedge gbclk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$fatal(1, "Timeout");
		end
	end

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else begin
			$display("ERROR: t=%0t %s expected %0h actual %0h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "Stopped at first error");
		end
	endtask

	// External bus follows the CPU whenever the DMA is idle
	task automatic passthrough_check();
		if (!dma_active) begin
			check("ext_adr", cpu_adr, ext_adr);
			check("ext_rd", 16'(cpu_rd), 16'(ext_rd));
			check("ext_wr", 16'(cpu_wr), 16'(ext_wr));
			check("ext_wdata", 16'(cpu_wdata), 16'(ext_wdata));
		end
	endtask

	task automatic do_write(input addr_t adr, input data_t data);
		cpu_adr   = adr;
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		#5 passthrough_check();
		@(negedge gbclk);
		cpu_wr = 1'b0;
		check("cpu_rdata", 16'(last_rd), 16'(cpu_rdata));
	endtask

	task automatic do_read(input addr_t adr, input data_t exp);
		cpu_adr = adr;
		cpu_rd  = 1'b1;
		#5 passthrough_check();
		@(negedge gbclk);
		cpu_rd = 1'b0;
		check("cpu_rdata", 16'(exp), 16'(cpu_rdata));
		last_rd = exp;
	endtask

	// CPU access that must lose to a PPU request on the same memory
	task automatic ppu_access(input logic vram_side, input logic wr, input data_t data);
		int    pidx;
		addr_t cadr;
		if (vram_side) begin
			pidx         = $urandom % 512;
			cadr         = addr_t'(16'h8000 + $urandom % 512);
			ppu_adr      = addr_t'(16'h8000 + pidx);
			ppu_vram_req = 1'b1;
		end else begin
			pidx        = $urandom % `GB_OAM_BYTES;
			cadr        = addr_t'(16'hfe00 + $urandom % `GB_OAM_BYTES);
			ppu_adr     = addr_t'(16'hfe00 + pidx);
			ppu_oam_req = 1'b1;
		end
		if (wr) begin
			do_write(cadr, data);
		end else begin
			do_read(cadr, `GB_OPEN_BUS);
		end
		if (vram_side) begin
			check("ppu_vram_data", 16'(vram_m[pidx]), 16'(ppu_vram_data));
		end else begin
			check("ppu_oam_data", 16'(oam_m[pidx]), 16'(ppu_oam_data));
		end
		ppu_vram_req = 1'b0;
		ppu_oam_req  = 1'b0;
	endtask

	task automatic run_dma(input data_t page, input logic from_vram);
		int    active_cycles;
		addr_t src;
		active_cycles = 0;
		do_write(`GB_DMA_REG_ADR, page);
		while (dma_active) begin
			active_cycles++;
			if (active_cycles == 40) begin
				do_write(`GB_DMA_REG_ADR, ~page);
			end else if (active_cycles % 2 == 1) begin
				do_read(addr_t'(16'hfe00 + $urandom % `GB_OAM_BYTES), `GB_OPEN_BUS);
			end else begin
				@(negedge gbclk);
			end
		end
		check("dma_active cycles", 16'(`GB_OAM_BYTES + 1), 16'(active_cycles));
		for (int i = 0; i < `GB_OAM_BYTES; i++) begin
			src      = {page, 8'(i)};
			oam_m[i] = from_vram ? vram_m[src[12:0]] : (src[7:0] ^ src[15:8]);
		end
		page_m = page;
		do_read(`GB_DMA_REG_ADR, page_m);
		for (int i = 0; i < `GB_OAM_BYTES; i++) begin
			do_read(addr_t'(16'hfe00 + i), oam_m[i]);
		end
	endtask

	function automatic addr_t ext_address();
		addr_t x;
		x = addr_t'($urandom);
		if (x[15:13] == 3'b100) begin
			x[15] = 1'b0;
		end else if (x >= 16'hfe00) begin
			x[9] = 1'b0;
		end
		return x;
	endfunction

	function automatic addr_t unmapped_address();
		case ($urandom % 4)
			0:       return addr_t'(16'hfea0 + $urandom % 96);
			1:       return addr_t'(16'hff00 + $urandom % 70);
			2:       return addr_t'(16'hff47 + $urandom % 57);
			default: return 16'hffff;
		endcase
	endfunction

	initial begin
		void'($urandom(32'he232));
		rst          = 1'b1;
		cpu_adr      = '0;
		cpu_wdata    = '0;
		cpu_rd       = 1'b0;
		cpu_wr       = 1'b0;
		ppu_vram_req = 1'b0;
		ppu_oam_req  = 1'b0;
		ppu_adr      = '0;
		page_m       = '0;
		last_rd      = '0;
		repeat (3) @(posedge gbclk);
		@(negedge gbclk);
		rst = 1'b0;
		check("dma_active", 16'h0, 16'(dma_active));
		check("ext_rd", 16'h0, 16'(ext_rd));
		check("ext_wr", 16'h0, 16'(ext_wr));
		check("cpu_rdata", 16'h0, 16'(cpu_rdata));

		// Known contents for VRAM pages 80 and 81, the OAM table and HRAM
		for (int i = 0; i < 512; i++) begin
			vram_m[i] = data_t'($urandom);
			do_write(addr_t'(16'h8000 + i), vram_m[i]);
		end
		for (int i = 0; i < `GB_OAM_BYTES; i++) begin
			oam_m[i] = data_t'($urandom);
			do_write(addr_t'(16'hfe00 + i), oam_m[i]);
		end
		for (int i = 0; i < `GB_HRAM_DEPTH - 1; i++) begin
			hram_m[i] = data_t'($urandom);
			do_write(addr_t'(16'hff80 + i), hram_m[i]);
		end

		for (int op = 0; op < NUM_OPS; op++) begin
			r    = $urandom;
			d    = data_t'($urandom);
			kind = $urandom % 14;
			if (op % DMA_EVERY == DMA_EVERY - 1) begin
				if ((op / DMA_EVERY) % 2 == 0) begin
					run_dma(data_t'(8'h80 + $urandom % 2), 1'b1);
				end else begin
					p = data_t'($urandom);
					if (p[7:5] == 3'b100) begin
						p[7] = 1'b0;
					end else if (p >= 8'hfe) begin
						p[1] = 1'b0;
					end
					run_dma(p, 1'b0);
				end
			end else begin
				case (kind)
					0, 1, 2, 3: begin
						idx = $urandom % 512;
						a   = addr_t'(16'h8000 + idx);
						if (r[0]) begin
							do_write(a, d);
							vram_m[idx] = d;
						end else begin
							do_read(a, vram_m[idx]);
						end
					end
					4, 5, 6: begin
						idx = $urandom % `GB_OAM_BYTES;
						a   = addr_t'(16'hfe00 + idx);
						if (r[0]) begin
							do_write(a, d);
							oam_m[idx] = d;
						end else begin
							do_read(a, oam_m[idx]);
						end
					end
					7, 8: begin
						idx = $urandom % (`GB_HRAM_DEPTH - 1);
						a   = addr_t'(16'hff80 + idx);
						if (r[0]) begin
							do_write(a, d);
							hram_m[idx] = d;
						end else begin
							do_read(a, hram_m[idx]);
						end
					end
					9, 10: begin
						a = ext_address();
						if (r[0]) begin
							do_write(a, d);
						end else begin
							do_read(a, a[7:0] ^ a[15:8]);
						end
					end
					11: begin
						a = unmapped_address();
						if (r[0]) begin
							do_write(a, d);
						end else begin
							do_read(a, `GB_OPEN_BUS);
						end
					end
					12:      do_read(`GB_DMA_REG_ADR, page_m);
					default: ppu_access(r[1], r[0], d);
				endcase
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// File: verif/gb_bus_properties.sv
`timescale 1ns/1ps

module gb_bus_properties (
	input logic                gbclk,
	input logic                rst,
	input logic                vram_we,
	input logic                ppu_vram_gnt,
	input logic                ext_wr,
	input logic                dma_active,
	input logic                dma_start,
	input gb_bus_pkg::region_e dma_region
);

	import gb_bus_pkg::*;

	no_vram_write_on_ppu_grant: assert property (@(posedge gbclk) disable iff (rst)
		!(vram_we && ppu_vram_gnt)) else $error("VRAM written while PPU holds VRAM");

	// DMA owns the external bus with an external source page
	no_ext_write_under_dma: assert property (@(posedge gbclk) disable iff (rst)
		!(ext_wr && dma_active && dma_region == REG_EXT))
		else $error("External write while DMA owns the bus");

	no_start_while_active: assert property (@(posedge gbclk) disable iff (rst)
		!(dma_start && dma_active)) else $error("DMA restarted while active");

endmodule

bind gb_bus_arbiter gb_bus_properties props (
	.gbclk, .rst, .vram_we, .ppu_vram_gnt, .ext_wr, .dma_active, .dma_start, .dma_region
);

// File: rtl/gb_bus_top.sv
`timescale 1ns/1ps
`include "gb_bus_config.svh"

module gb_bus_top (
	input  logic              gbclk,
	input  logic              rst,
	input  gb_bus_pkg::addr_t cpu_adr,
	input  gb_bus_pkg::data_t cpu_wdata,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	input  logic              ppu_vram_req,
	input  logic              ppu_oam_req,
	input  gb_bus_pkg::addr_t ppu_adr,
	input  gb_bus_pkg::data_t ext_rdata,
	output gb_bus_pkg::data_t cpu_rdata,
	output gb_bus_pkg::data_t ppu_vram_data,
	output gb_bus_pkg::data_t ppu_oam_data,
	output gb_bus_pkg::addr_t ext_adr,
	output logic              ext_rd,
	output logic              ext_wr,
	output gb_bus_pkg::data_t ext_wdata,
	output logic              dma_active
);

	import gb_bus_pkg::*;

	region_e   cpu_region, dma_region;
	vram_adr_t vram_adr;
	data_t     vram_wdata;
	logic      vram_we;
	oam_adr_t  oam_adr;
	data_t     oam_wdata;
	logic      oam_we;
	hram_adr_t hram_adr;
	logic      hram_we;
	data_t     hram_rdata;
	logic      dma_start, dma_rd, dma_wr;
	data_t     dma_rdata, dma_wdata, dma_page;
	addr_t     dma_src_adr;
	oam_adr_t  dma_oam_adr;

	gb_addr_decode cpu_decode (.adr(cpu_adr), .region(cpu_region));
	gb_addr_decode dma_decode (.adr(dma_src_adr), .region(dma_region));

	gb_bus_arbiter arbiter (
		.gbclk, .rst, .cpu_region, .dma_region,
		.cpu_adr, .cpu_wdata, .cpu_rd, .cpu_wr,
		.ppu_vram_req, .ppu_oam_req, .ppu_adr, .ext_rdata,
		.vram_rdata(ppu_vram_data), .oam_rdata(ppu_oam_data), .hram_rdata,
		.dma_active, .dma_src_adr, .dma_rd, .dma_oam_adr, .dma_wdata, .dma_wr, .dma_page,
		.cpu_rdata, .ext_adr, .ext_rd, .ext_wr, .ext_wdata,
		.vram_adr, .vram_wdata, .vram_we,
		.oam_adr, .oam_wdata, .oam_we,
		.hram_adr, .hram_we, .dma_start, .dma_rdata
	);

	gb_oam_dma dma (
		.gbclk, .rst, .dma_start, .cpu_wdata, .dma_rdata,
		.dma_active, .dma_page, .dma_src_adr, .dma_rd,
		.dma_oam_adr, .dma_wdata, .dma_wr
	);

	// PPU data comes straight off the array outputs
	gb_ram #(.DEPTH(`GB_VRAM_DEPTH)) vram (
		.gbclk, .adr(vram_adr), .wdata(vram_wdata), .we(vram_we), .rdata(ppu_vram_data)
	);

	gb_ram #(.DEPTH(`GB_OAM_DEPTH)) oam (
		.gbclk, .adr(oam_adr), .wdata(oam_wdata), .we(oam_we), .rdata(ppu_oam_data)
	);

	gb_ram #(.DEPTH(`GB_HRAM_DEPTH)) hram (
		.gbclk, .adr(hram_adr), .wdata(cpu_wdata), .we(hram_we), .rdata(hram_rdata)
	);

endmodule

// File: rtl/gb_bus_arbiter.sv
`timescale 1ns/1ps
`include "gb_bus_config.svh"

module gb_bus_arbiter (
	input  logic                  gbclk,
	input  logic                  rst,
	input  gb_bus_pkg::region_e   cpu_region,
	input  gb_bus_pkg::region_e   dma_region,
	input  gb_bus_pkg::addr_t     cpu_adr,
	input  gb_bus_pkg::data_t     cpu_wdata,
	input  logic                  cpu_rd,
	input  logic                  cpu_wr,
	input  logic                  ppu_vram_req,
	input  logic                  ppu_oam_req,
	input  gb_bus_pkg::addr_t     ppu_adr,
	input  gb_bus_pkg::data_t     ext_rdata,
	input  gb_bus_pkg::data_t     vram_rdata,
	input  gb_bus_pkg::data_t     oam_rdata,
	input  gb_bus_pkg::data_t     hram_rdata,
	input  logic                  dma_active,
	input  gb_bus_pkg::addr_t     dma_src_adr,
	input  logic                  dma_rd,
	input  gb_bus_pkg::oam_adr_t  dma_oam_adr,
	input  gb_bus_pkg::data_t     dma_wdata,
	input  logic                  dma_wr,
	input  gb_bus_pkg::data_t     dma_page,
	output gb_bus_pkg::data_t     cpu_rdata,
	output gb_bus_pkg::addr_t     ext_adr,
	output logic                  ext_rd,
	output logic                  ext_wr,
	output gb_bus_pkg::data_t     ext_wdata,
	output gb_bus_pkg::vram_adr_t vram_adr,
	output gb_bus_pkg::data_t     vram_wdata,
	output logic                  vram_we,
	output gb_bus_pkg::oam_adr_t  oam_adr,
	output gb_bus_pkg::data_t     oam_wdata,
	output logic                  oam_we,
	output gb_bus_pkg::hram_adr_t hram_adr,
	output logic                  hram_we,
	output logic                  dma_start,
	output gb_bus_pkg::data_t     dma_rdata
);

	import gb_bus_pkg::*;

	logic    ppu_vram_gnt, dma_vram_gnt, cpu_vram_gnt;
	logic    ppu_oam_gnt, dma_oam_gnt, cpu_oam_gnt;
	logic    dma_ext_gnt;
	region_e cpu_src_d, cpu_src_q, dma_src_d, dma_src_q;
	logic    rd_q;
	data_t   ext_q, hold_q, cpu_mux;

	assign ppu_vram_gnt = ppu_vram_req;
	assign dma_vram_gnt = !ppu_vram_req && dma_active && dma_region == REG_VRAM;
	assign cpu_vram_gnt = !ppu_vram_gnt && !dma_vram_gnt && cpu_region == REG_VRAM;
	assign ppu_oam_gnt  = ppu_oam_req;
	assign dma_oam_gnt  = !ppu_oam_req && dma_active;
	assign cpu_oam_gnt  = !ppu_oam_gnt && !dma_oam_gnt && cpu_region == REG_OAM;
	assign dma_ext_gnt  = dma_active && dma_region == REG_EXT;

	assign dma_start = cpu_wr && cpu_region == REG_DMA_REG && !dma_active;

	assign vram_adr   = ppu_vram_gnt ? ppu_adr[12:0] :
			    dma_vram_gnt ? dma_src_adr[12:0] : cpu_adr[12:0];
	assign vram_wdata = cpu_wdata;
	assign vram_we    = cpu_vram_gnt && cpu_wr;

	assign oam_adr   = ppu_oam_gnt ? ppu_adr[7:0] :
			   dma_oam_gnt ? dma_oam_adr : cpu_adr[7:0];
	assign oam_wdata = dma_oam_gnt ? dma_wdata : cpu_wdata;
	assign oam_we    = dma_oam_gnt ? dma_wr : (cpu_oam_gnt && cpu_wr);

	assign hram_adr = cpu_adr[6:0];
	assign hram_we  = cpu_wr && cpu_region == REG_HRAM;

	// DMA never writes the external bus
	assign ext_adr   = dma_ext_gnt ? dma_src_adr : cpu_adr;
	assign ext_rd    = dma_ext_gnt ? dma_rd : cpu_rd;
	assign ext_wr    = !dma_ext_gnt && cpu_wr;
	assign ext_wdata = cpu_wdata;

	// A lost access reads back as open bus
	always_comb begin
		cpu_src_d = cpu_region;
		if ((cpu_region == REG_VRAM && !cpu_vram_gnt) ||
		    (cpu_region == REG_OAM && !cpu_oam_gnt) ||
		    (cpu_region == REG_EXT && dma_ext_gnt)) begin
			cpu_src_d = REG_NONE;
		end
		dma_src_d = REG_NONE;
		if (dma_vram_gnt || dma_ext_gnt) begin
			dma_src_d = dma_region;
		end
	end

	always_ff @(posedge gbclk) begin
		if (ext_rd) begin
			ext_q <= ext_rdata;
		end
		if (rst) begin
			rd_q      <= 1'b0;
			cpu_src_q <= REG_NONE;
			dma_src_q <= REG_NONE;
			hold_q    <= '0;
		end else begin
			rd_q      <= cpu_rd;
			dma_src_q <= dma_src_d;
			hold_q    <= cpu_rdata;
			if (cpu_rd) begin
				cpu_src_q <= cpu_src_d;
			end
		end
	end

	always_comb begin
		case (cpu_src_q)
			REG_EXT:     cpu_mux = ext_q;
			REG_VRAM:    cpu_mux = vram_rdata;
			REG_OAM:     cpu_mux = oam_rdata;
			REG_HRAM:    cpu_mux = hram_rdata;
			REG_DMA_REG: cpu_mux = dma_page;
			default:     cpu_mux = `GB_OPEN_BUS;
		endcase
		case (dma_src_q)
			REG_EXT:  dma_rdata = ext_q;
			REG_VRAM: dma_rdata = vram_rdata;
			default:  dma_rdata = `GB_OPEN_BUS;
		endcase
	end

	// Fresh data right after a read, then held
	assign cpu_rdata = rd_q ? cpu_mux : hold_q;

endmodule

// File: rtl/gb_oam_dma.sv
`timescale 1ns/1ps
`include "gb_bus_config.svh"

module gb_oam_dma (
	input  logic                 gbclk,
	input  logic                 rst,
	input  logic                 dma_start,
	input  gb_bus_pkg::data_t    cpu_wdata,
	input  gb_bus_pkg::data_t    dma_rdata,
	output logic                 dma_active,
	output gb_bus_pkg::data_t    dma_page,
	output gb_bus_pkg::addr_t    dma_src_adr,
	output logic                 dma_rd,
	output gb_bus_pkg::oam_adr_t dma_oam_adr,
	output gb_bus_pkg::data_t    dma_wdata,
	output logic                 dma_wr
);

	import gb_bus_pkg::*;

	dma_state_e state;
	oam_adr_t   cnt;
	oam_adr_t   wr_idx;
	logic       wr_pending;
	data_t      page;

	assign dma_active  = (state != DMA_IDLE);
	assign dma_rd      = (state == DMA_RUN);
	assign dma_src_adr = {page, cnt};
	assign dma_page    = page;

	// Write side trails the read side by one cycle
	assign dma_oam_adr = wr_idx;
	assign dma_wr      = wr_pending;
	assign dma_wdata   = dma_rdata;

	always_ff @(posedge gbclk) begin
		wr_idx <= cnt;
		if (rst) begin
			state      <= DMA_IDLE;
			cnt        <= '0;
			wr_pending <= 1'b0;
			page       <= '0;
		end else begin
			wr_pending <= dma_rd;
			case (state)
				DMA_IDLE: begin
					if (dma_start) begin
						state <= DMA_RUN;
						cnt   <= '0;
						page  <= cpu_wdata;
					end
				end
				DMA_RUN: begin
					cnt <= cnt + 1'b1;
					if (cnt == oam_adr_t'(`GB_OAM_BYTES - 1)) begin
						state <= DMA_LAST;
					end
				end
				// Only the final OAM write left
				DMA_LAST: state <= DMA_IDLE;
				default:  state <= DMA_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/gb_addr_decode.sv
`timescale 1ns/1ps
`include "gb_bus_config.svh"

module gb_addr_decode (
	input  gb_bus_pkg::addr_t   adr,
	output gb_bus_pkg::region_e region
);

	import gb_bus_pkg::*;

	// Checked top down, first match wins
	always_comb begin
		if (!adr[15]) begin
			// Cartridge ROM
			region = REG_EXT;
		end else if (adr[15:13] == 3'b100) begin
			region = REG_VRAM;
		end else if (adr < 16'hfe00) begin
			// Cartridge RAM, work RAM and its echo
			region = REG_EXT;
		end else if (adr < 16'hfea0) begin
			region = REG_OAM;
		end else if (adr == `GB_DMA_REG_ADR) begin
			region = REG_DMA_REG;
		end else if (adr >= 16'hff80 && adr != 16'hffff) begin
			region = REG_HRAM;
		end else begin
			// FEA0-FEFF hole, other IO, FFFF
			region = REG_NONE;
		end
	end

endmodule

// File: rtl/gb_ram.sv
`timescale 1ns/1ps

module gb_ram #(
	parameter int DEPTH = 256
) (
	input  logic                     gbclk,
	input  logic [$clog2(DEPTH)-1:0] adr,
	input  gb_bus_pkg::data_t        wdata,
	input  logic                     we,
	output gb_bus_pkg::data_t        rdata
);

	gb_bus_pkg::data_t mem [DEPTH];

	// Read every cycle, old data on a same-cycle write
	always_ff @(posedge gbclk) begin
		if (we) begin
			mem[adr] <= wdata;
		end
		rdata <= mem[adr];
	end

endmodule

// File: rtl/gb_bus_pkg.sv
package gb_bus_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;

	typedef logic [12:0] vram_adr_t;
	typedef logic [7:0]  oam_adr_t;
	typedef logic [6:0]  hram_adr_t;

	typedef enum logic [2:0] {
		REG_EXT,
		REG_VRAM,
		REG_OAM,
		REG_HRAM,
		REG_DMA_REG,
		REG_NONE
	} region_e;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_RUN,
		DMA_LAST
	} dma_state_e;

endpackage

// File: rtl/gb_bus_config.svh
`ifndef GB_BUS_CONFIG_SVH
`define GB_BUS_CONFIG_SVH

// Value seen on a read nobody answers
`define GB_OPEN_BUS 8'hff

// Bytes moved per OAM DMA, also the sprite table size
`define GB_OAM_BYTES 160

// Array depths
`define GB_VRAM_DEPTH 8192
`define GB_OAM_DEPTH 256
`define GB_HRAM_DEPTH 128

// DMA start register in the IO page
`define GB_DMA_REG_ADR 16'hff46

`endif
